/* mapper_cfg.svh */
`ifndef MAPPER_CFG_SVH
`define MAPPER_CFG_SVH

// Register offsets within $5xxx, decoded from CPU A2..A0
`define CFG_PRG_BASE_HI 3'd0  // PRG base A26..A22
`define CFG_PRG_BASE_LO 3'd1  // PRG base A21..A14
`define CFG_PRG_MASK    3'd2  // PRG mask A18..A14
`define CFG_CHR_BANK    3'd3  // Direct CHR bank, goes to the latch
`define CFG_CHR_MASK    3'd4  // CHR mask A17..A13
`define CFG_SRAM_PAGE   3'd5  // SRAM page 0..3
`define CFG_MAPPER      3'd6  // Mapper code plus flags
`define CFG_OPTIONS     3'd7  // Enables, mirroring, lockout

// Mapper codes as written to $5xx6 bits 4..0
`define MAP_NROM  5'd0
`define MAP_MMC1  5'd1
`define MAP_UXROM 5'd2
`define MAP_CNROM 5'd3
`define MAP_AXROM 5'd7

// MMC1 loader idle value, sentinel one in bit 5
`define MMC1_SHIFT_EMPTY 6'b100000

// Fixed last 16K bank for UxROM at $C000
`define PRG_LAST_BANK 5'b11111

`endif

/* mapper_pkg.sv */
`default_nettype none

package mapper_pkg;

	typedef logic [13:0] prg_addr_t;  // Flash/SRAM A26..A13
	typedef logic [12:0] prg_base_t;  // PRG base A26..A14
	typedef logic [4:0]  prg_mask_t;  // PRG mask A18..A14
	typedef logic [7:0]  chr_addr_t;  // CHR A17..A10
	typedef logic [4:0]  chr_mask_t;  // CHR mask A17..A13
	typedef logic [4:0]  mapper_id_t; // Mapper code
	typedef logic [7:0]  bank_t;      // One bank register

	// One CPU bus cycle as seen by the cartridge
	typedef struct packed {
		logic        romsel;  // Low for $8000..$FFFF
		logic        rw;      // Low on writes
		logic [14:0] addr;    // CPU A14..A0
		logic [7:0]  data;    // CPU D7..D0
	} cpu_bus_t;

	// Contents of the $5xxx register file
	typedef struct packed {
		prg_base_t  prg_base;
		prg_mask_t  prg_mask;
		chr_mask_t  chr_mask;
		logic [1:0] sram_page;
		mapper_id_t mapper;
		logic [2:0] flags;       // Spare mapper flags, $5xx6 bits 7..5
		logic       sram_en;
		logic       chr_wr_en;   // CHR-RAM writable
		logic       prg_wr_en;   // Flash writable
		logic [1:0] mirroring;   // Bit 0 picks A10 or A11
		logic       rom_at_6000; // Flash instead of SRAM at $6000
	} cart_cfg_t;

	// Mapper bank state
	typedef struct packed {
		bank_t      latch;      // UxROM/CNROM/AxROM latch, also NROM CHR bank
		logic [4:0] mmc1_ctrl;  // Mirroring, PRG mode, CHR mode
		logic [4:0] mmc1_chr0;
		logic [4:0] mmc1_chr1;
		logic [4:0] mmc1_prg;
	} bank_set_t;

endpackage

`default_nettype wire

/* cart_config_regs.sv */
`default_nettype none

`include "mapper_cfg.svh"

module cart_config_regs (
	input  wire                   m2,
	input  wire                   ppu_addr_in,    // Async reset, active high
	input  mapper_pkg::cpu_bus_t  cpu,
	output mapper_pkg::cart_cfg_t cfg,
	output mapper_pkg::bank_t     direct_bank,
	output logic                  direct_bank_wr,
	output logic                  mapper_wr
);

	logic lockout;  // Freezes $5xxx until reset
	logic cfg_wr;   // Write cycle aimed at $5000..$5FFF

	// Write at $5xxx while unlocked
	assign cfg_wr = !cpu.rw && cpu.romsel && (cpu.addr[14:12] == 3'b101) && !lockout;

	// Bank byte goes straight to bank_regs, loaded on the same edge
	assign direct_bank    = cpu.data;
	assign direct_bank_wr = cfg_wr && (cpu.addr[2:0] == `CFG_CHR_BANK);
	assign mapper_wr      = cfg_wr && (cpu.addr[2:0] == `CFG_MAPPER);  // Lets MMC1 loader reset

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cfg     <= '0;  // NROM, all enables off
			lockout <= 1'b0;
		end
		else if (cfg_wr)
		begin
			case (cpu.addr[2:0])
				`CFG_PRG_BASE_HI: cfg.prg_base[12:8] <= cpu.data[4:0];  // A26..A22
				`CFG_PRG_BASE_LO: cfg.prg_base[7:0] <= cpu.data;        // A21..A14
				`CFG_PRG_MASK:    cfg.prg_mask <= cpu.data[4:0];
				`CFG_CHR_MASK:    cfg.chr_mask <= cpu.data[4:0];
				`CFG_SRAM_PAGE:   cfg.sram_page <= cpu.data[1:0];
				`CFG_MAPPER:
				begin
					cfg.mapper <= cpu.data[4:0];
					cfg.flags  <= cpu.data[7:5];
				end
				`CFG_OPTIONS:
				begin
					// Bit 6 is unused
					lockout         <= cpu.data[7];
					cfg.rom_at_6000 <= cpu.data[5];
					cfg.mirroring   <= cpu.data[4:3];
					cfg.prg_wr_en   <= cpu.data[2];
					cfg.chr_wr_en   <= cpu.data[1];
					cfg.sram_en     <= cpu.data[0];
				end
				default: ;  // $5xx3 handled by bank_regs
			endcase
		end
	end

	// Once locked, no later edge may alter the configuration
	a_lockout_freeze: assert property (
		@(posedge m2) disable iff (ppu_addr_in)
		lockout |=> $stable(cfg)
	);

endmodule

`default_nettype wire

/* bank_regs.sv */
`default_nettype none

`include "mapper_cfg.svh"

module bank_regs (
	input  wire                   m2,
	input  wire                   ppu_addr_in,     // Async reset, active high
	input  mapper_pkg::cpu_bus_t  cpu,
	input  mapper_pkg::cart_cfg_t cfg,
	input  mapper_pkg::bank_t     direct_bank,
	input  wire                   direct_bank_wr,
	input  wire                   mapper_wr,
	output mapper_pkg::bank_set_t banks
);

	import mapper_pkg::*;

	mapper_id_t new_mapper;  // Code being written to $5xx6
	logic [5:0] shift_q;     // MMC1 load register, sentinel marks fill level
	logic [5:0] shift_nxt;
	logic       rom_wr;      // Write to $8000..$FFFF
	logic       latch_map;   // Simple latch mappers
	logic       mmc1_map;
	logic       mmc1_rst;    // Loader reset request

	assign new_mapper = cpu.data[4:0];
	assign rom_wr     = !cpu.rw && !cpu.romsel;
	assign latch_map  = (cfg.mapper == `MAP_UXROM) || (cfg.mapper == `MAP_CNROM) ||
		(cfg.mapper == `MAP_AXROM);
	assign mmc1_map   = (cfg.mapper == `MAP_MMC1);

	// Serial data enters at the top, bit 0 first
	assign shift_nxt = {cpu.data[0], shift_q[5:1]};

	// Bit 7 write, or switching the mapper to MMC1
	assign mmc1_rst = (rom_wr && mmc1_map && cpu.data[7]) ||
		(mapper_wr && (new_mapper == `MAP_MMC1));

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			banks   <= '0;
			shift_q <= `MMC1_SHIFT_EMPTY;
		end
		else
		begin
			// Bank latch
			if (direct_bank_wr)
				banks.latch <= direct_bank;   // $5xx3, any mapper
			else if (rom_wr && latch_map)
				banks.latch <= cpu.data;      // Full byte, unused bits kept

			// MMC1 loader
			if (mmc1_rst)
			begin
				shift_q               <= `MMC1_SHIFT_EMPTY;
				banks.mmc1_ctrl[3:2]  <= 2'b11;  // Fix last bank at $C000
			end
			else if (rom_wr && mmc1_map)
			begin
				if (shift_nxt[0])
				begin
					// Fifth write, target picked by A14..A13
					case (cpu.addr[14:13])
						2'b00: banks.mmc1_ctrl <= shift_nxt[5:1];  // $8000
						2'b01: banks.mmc1_chr0 <= shift_nxt[5:1];  // $A000
						2'b10: banks.mmc1_chr1 <= shift_nxt[5:1];  // $C000
						2'b11: banks.mmc1_prg  <= shift_nxt[5:1];  // $E000
					endcase
					shift_q <= `MMC1_SHIFT_EMPTY;
				end
				else
					shift_q <= shift_nxt;
			end
		end
	end

	// Sentinel must always be present somewhere in the register
	a_shift_sentinel: assert property (
		@(posedge m2) disable iff (ppu_addr_in)
		shift_q != 6'b000000
	);

endmodule

`default_nettype wire

/* prg_bank_map.sv */
`default_nettype none

`include "mapper_cfg.svh"

module prg_bank_map (
	input  mapper_pkg::cpu_bus_t  cpu,
	input  mapper_pkg::cart_cfg_t cfg,
	input  mapper_pkg::bank_set_t banks,
	output mapper_pkg::prg_addr_t cpu_addr_out,
	output logic                  flash_we,
	output logic                  flash_oe,
	output logic                  sram_ce,
	output logic                  sram_we,
	output logic                  sram_oe
);

	import mapper_pkg::*;

	logic [5:0] prg_bank;  // A18..A13 before base and mask
	prg_mask_t  prg_hi;    // Masked A18..A14
	logic       at_6000;   // $6000..$7FFF
	logic       rom_acc;   // Flash access

	assign at_6000 = cpu.romsel && (cpu.addr[14:13] == 2'b11);
	assign rom_acc = !cpu.romsel || (at_6000 && cfg.rom_at_6000);

	always_comb
	begin
		case (cfg.mapper)
			`MAP_UXROM:  // 16K switchable below $C000
				prg_bank = {cpu.addr[14] ? `PRG_LAST_BANK : banks.latch[4:0], cpu.addr[13]};
			`MAP_AXROM:  // 32K pages
				prg_bank = {1'b0, banks.latch[2:0], cpu.addr[14:13]};
			`MAP_MMC1:
			begin
				case (banks.mmc1_ctrl[3:2])
					2'b10:  // First bank fixed at $8000
						prg_bank = cpu.addr[14] ? {1'b0, banks.mmc1_prg[3:0], cpu.addr[13]}
							: {5'b00000, cpu.addr[13]};
					2'b11:  // Last bank fixed at $C000
						prg_bank = cpu.addr[14] ? {5'b01111, cpu.addr[13]}
							: {1'b0, banks.mmc1_prg[3:0], cpu.addr[13]};
					default:  // 32K mode ignores prg bit 0
						prg_bank = {1'b0, banks.mmc1_prg[3:1], cpu.addr[14:13]};
				endcase
			end
			default:  // NROM, CNROM
				prg_bank = {3'b000, cpu.addr[14:13]};
		endcase
	end

	assign prg_hi = prg_bank[5:1] & ~cfg.prg_mask;

	// Flash gets base plus masked bank, SRAM gets only the page
	assign cpu_addr_out = rom_acc ? {cfg.prg_base | {8'b0, prg_hi}, prg_bank[0]}
		: {12'b0, cfg.sram_page};

	assign flash_we = cpu.rw | cpu.romsel | ~cfg.prg_wr_en;   // ROM area writes only
	assign flash_oe = ~cpu.rw | ~rom_acc;
	assign sram_ce  = ~(at_6000 & cfg.sram_en & ~cfg.rom_at_6000);
	assign sram_we  = cpu.rw;
	assign sram_oe  = ~cpu.rw;

	// Flash and SRAM never drive the data bus together
	always_comb
	begin
		a_no_bus_fight: assert final (flash_oe || sram_ce);
	end

endmodule

`default_nettype wire

/* chr_bank_map.sv */
`default_nettype none

`include "mapper_cfg.svh"

module chr_bank_map (
	input  wire   [13:0]          ppu_addr,
	input  wire                   ppu_rd,
	input  wire                   ppu_wr,
	input  mapper_pkg::cart_cfg_t cfg,
	input  mapper_pkg::bank_set_t banks,
	output mapper_pkg::chr_addr_t ppu_addr_out,
	output logic                  ppu_rd_out,
	output logic                  ppu_wr_out,
	output logic                  ppu_ciram_a10
);

	import mapper_pkg::*;

	chr_addr_t chr_bank;  // 1K bank, A17..A10

	always_comb
	begin
		case (cfg.mapper)
			`MAP_NROM, `MAP_CNROM:  // 8K from latch
				chr_bank = {banks.latch[4:0], ppu_addr[12:10]};
			`MAP_MMC1:
			begin
				if (!banks.mmc1_ctrl[4])
					chr_bank = {1'b0, banks.mmc1_chr0[4:1], ppu_addr[12:10]};  // 8K mode
				else if (!ppu_addr[12])
					chr_bank = {1'b0, banks.mmc1_chr0, ppu_addr[11:10]};       // 4K at $0000
				else
					chr_bank = {1'b0, banks.mmc1_chr1, ppu_addr[11:10]};       // 4K at $1000
			end
			default:  // UxROM, AxROM, fixed 8K
				chr_bank = {5'b00000, ppu_addr[12:10]};
		endcase
	end

	always_comb
	begin
		case (cfg.mapper)
			`MAP_AXROM:
				ppu_ciram_a10 = banks.latch[4];  // One-screen page
			`MAP_MMC1:
			begin
				case (banks.mmc1_ctrl[1:0])
					2'b00: ppu_ciram_a10 = 1'b0;         // One-screen low
					2'b01: ppu_ciram_a10 = 1'b1;         // One-screen high
					2'b10: ppu_ciram_a10 = ppu_addr[10]; // Vertical
					2'b11: ppu_ciram_a10 = ppu_addr[11]; // Horizontal
				endcase
			end
			default:
				ppu_ciram_a10 = cfg.mirroring[0] ? ppu_addr[11] : ppu_addr[10];
		endcase
	end

	assign ppu_addr_out = {chr_bank[7:3] & ~cfg.chr_mask, chr_bank[2:0]};

	// Pattern area only, nametables live in CIRAM
	assign ppu_rd_out = ppu_rd | ppu_addr[13];
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~cfg.chr_wr_en;

endmodule

`default_nettype wire

/* cart_mapper.sv */
`default_nettype none

module cart_mapper (
	input  wire                   m2,
	input  wire                   ppu_addr_in,   // Async reset, active high
	input  wire                   romsel,
	input  wire                   cpu_rw_in,
	input  wire   [14:0]          cpu_addr_in,
	input  wire   [7:0]           cpu_data_in,
	input  wire                   ppu_rd_in,
	input  wire                   ppu_wr_in,
	input  wire   [13:0]          ppu_addr,
	output mapper_pkg::prg_addr_t cpu_addr_out,
	output logic                  flash_we,
	output logic                  flash_oe,
	output logic                  sram_ce,
	output logic                  sram_we,
	output logic                  sram_oe,
	output mapper_pkg::chr_addr_t ppu_addr_out,
	output logic                  ppu_rd_out,
	output logic                  ppu_wr_out,
	output logic                  ppu_ciram_a10
);

	import mapper_pkg::*;

	cpu_bus_t  cpu;             // CPU pins bundled
	cart_cfg_t cfg;
	bank_t     direct_bank;     // $5xx3 data
	logic      direct_bank_wr;
	logic      mapper_wr;       // $5xx6 strobe
	bank_set_t banks;

	assign cpu.romsel = romsel;
	assign cpu.rw     = cpu_rw_in;
	assign cpu.addr   = cpu_addr_in;
	assign cpu.data   = cpu_data_in;

	cart_config_regs u_config (
		.m2             (m2),
		.ppu_addr_in    (ppu_addr_in),
		.cpu            (cpu),
		.cfg            (cfg),
		.direct_bank    (direct_bank),
		.direct_bank_wr (direct_bank_wr),
		.mapper_wr      (mapper_wr)
	);

	bank_regs u_banks (
		.m2             (m2),
		.ppu_addr_in    (ppu_addr_in),
		.cpu            (cpu),
		.cfg            (cfg),
		.direct_bank    (direct_bank),
		.direct_bank_wr (direct_bank_wr),
		.mapper_wr      (mapper_wr),
		.banks          (banks)
	);

	prg_bank_map u_prg (
		.cpu          (cpu),
		.cfg          (cfg),
		.banks        (banks),
		.cpu_addr_out (cpu_addr_out),
		.flash_we     (flash_we),
		.flash_oe     (flash_oe),
		.sram_ce      (sram_ce),
		.sram_we      (sram_we),
		.sram_oe      (sram_oe)
	);

	chr_bank_map u_chr (
		.ppu_addr      (ppu_addr),
		.ppu_rd        (ppu_rd_in),
		.ppu_wr        (ppu_wr_in),
		.cfg           (cfg),
		.banks         (banks),
		.ppu_addr_out  (ppu_addr_out),
		.ppu_rd_out    (ppu_rd_out),
		.ppu_wr_out    (ppu_wr_out),
		.ppu_ciram_a10 (ppu_ciram_a10)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
	output logic m2,
	output logic ppu_addr_in  // Reset, active high
);

	localparam int HALF_PERIOD  = 50;  // 100 unit period
	localparam int RESET_CYCLES = 8;

	initial
	begin
		m2 = 1'b0;
		forever #HALF_PERIOD m2 = ~m2;
	end

	initial
	begin
		ppu_addr_in = 1'b1;
		repeat (RESET_CYCLES) @(posedge m2);
		#10;  // Release away from the edge
		ppu_addr_in = 1'b0;
	end

endmodule

`default_nettype wire

/* tb_mapper_checker.sv */
`default_nettype none

module tb_mapper_checker (
	input  wire             m2,
	input  wire             check_en,       // Step wants a compare
	input  wire             is_ppu,         // PPU step, else CPU read
	input  wire  [19:0]     exp_val,
	input  wire  [8*16-1:0] test_name,
	input  wire  [13:0]     cpu_addr_out,
	input  wire             flash_we,
	input  wire             flash_oe,
	input  wire             sram_ce,
	input  wire             sram_we,
	input  wire             sram_oe,
	input  wire  [7:0]      ppu_addr_out,
	input  wire             ppu_rd_out,
	input  wire             ppu_wr_out,
	input  wire             ppu_ciram_a10,
	output int              errors,
	output int              checks
);

	logic [19:0] actual;  // Same packing as the stimulus file

	// CPU: strobe nibble, SRAM we/oe, then the flash/SRAM address
	// PPU: rd/wr/a10 nibble, then the CHR address
	always_comb
	begin
		if (is_ppu)
			actual = {8'h00, 1'b0, ppu_rd_out, ppu_wr_out, ppu_ciram_a10, ppu_addr_out};
		else
			actual = {1'b0, flash_we, flash_oe, sram_ce, sram_we, sram_oe, cpu_addr_out};
	end

	// Falling edge, mid cycle, outputs long settled
	always @(negedge m2)
	begin
		if (check_en)
		begin
			checks++;
			if (actual !== exp_val)  // X or Z also fails
			begin
				errors++;
				$display("FAIL %0s: expected %05h, actual %05h", test_name, exp_val, actual);
			end
		end
	end

endmodule

`default_nettype wire

/* tb_cart_mapper.sv */
`default_nettype none

module tb_cart_mapper;

	localparam int MAX_STEPS = 64;

	logic            m2;
	logic            ppu_addr_in;           // Reset
	logic            romsel;
	logic            cpu_rw_in;
	logic [14:0]     cpu_addr_in;
	logic [7:0]      cpu_data_in;
	logic            ppu_rd_in;
	logic            ppu_wr_in;
	logic [13:0]     ppu_addr;
	logic [13:0]     cpu_addr_out;
	logic            flash_we;
	logic            flash_oe;
	logic            sram_ce;
	logic            sram_we;
	logic            sram_oe;
	logic [7:0]      ppu_addr_out;
	logic            ppu_rd_out;
	logic            ppu_wr_out;
	logic            ppu_ciram_a10;
	logic [7:0]      op_mem [MAX_STEPS];    // W, R or P
	logic [8*16-1:0] name_mem [MAX_STEPS];
	logic [15:0]     addr_mem [MAX_STEPS];  // Full CPU or PPU address
	logic [7:0]      data_mem [MAX_STEPS];
	logic [19:0]     exp_mem [MAX_STEPS];
	logic            check_en;
	logic            is_ppu;
	logic [19:0]     exp_val;
	logic [8*16-1:0] test_name;
	int              n_steps;
	int              bad_ops;               // Unknown opcodes in the file
	int              errors;
	int              checks;

	tb_clock_gen u_clk (.m2(m2), .ppu_addr_in(ppu_addr_in));

	cart_mapper i_cart_mapper (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw_in(cpu_rw_in),
		.cpu_addr_in(cpu_addr_in), .cpu_data_in(cpu_data_in), .ppu_rd_in(ppu_rd_in),
		.ppu_wr_in(ppu_wr_in), .ppu_addr(ppu_addr), .cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we), .flash_oe(flash_oe), .sram_ce(sram_ce), .sram_we(sram_we),
		.sram_oe(sram_oe), .ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out), .ppu_ciram_a10(ppu_ciram_a10)
	);

	tb_mapper_checker u_check (
		.m2(m2), .check_en(check_en), .is_ppu(is_ppu), .exp_val(exp_val),
		.test_name(test_name), .cpu_addr_out(cpu_addr_out), .flash_we(flash_we),
		.flash_oe(flash_oe), .sram_ce(sram_ce), .sram_we(sram_we), .sram_oe(sram_oe),
		.ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out), .ppu_wr_out(ppu_wr_out),
		.ppu_ciram_a10(ppu_ciram_a10), .errors(errors), .checks(checks)
	);

	// Whole stimulus file into memory, comment lines skipped
	task automatic load_steps(output int count);
		int              fd;
		int              code;
		logic [7:0]      op;
		logic [8*16-1:0] name;
		logic [15:0]     addr;
		logic [7:0]      data;
		logic [19:0]     expv;
		logic [8*128-1:0] skip;
		count = 0;
		fd = $fopen("cart_mapper_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd) && count < MAX_STEPS)
			begin
				code = $fscanf(fd, "%s", op);
				if (code == 1 && op == "#")
					code = $fgets(skip, fd);  // Rest of the comment
				else if (code == 1)
				begin
					code = $fscanf(fd, "%s %h %h %h", name, addr, data, expv);
					if (code == 4)
					begin
						op_mem[count]   = op;
						name_mem[count] = name;
						addr_mem[count] = addr;
						data_mem[count] = data;
						exp_mem[count]  = expv;
						count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Bus idle first, so a write lasts exactly one m2 edge
	task automatic drive_step(input int i);
		logic [15:0] a;
		a           = addr_mem[i];
		romsel      = 1'b1;
		cpu_rw_in   = 1'b1;
		cpu_addr_in = 15'h0000;
		cpu_data_in = 8'h00;
		ppu_rd_in   = 1'b1;
		ppu_wr_in   = 1'b1;
		check_en    = 1'b0;
		test_name   = name_mem[i];
		exp_val     = exp_mem[i];
		case (op_mem[i])
			"W", "R":
			begin
				romsel      = ~a[15];  // Low for $8000..$FFFF
				cpu_addr_in = a[14:0];
				cpu_data_in = data_mem[i];
				cpu_rw_in   = (op_mem[i] == "R");
				check_en    = (op_mem[i] == "R");
				is_ppu      = 1'b0;
			end
			"P":
			begin
				ppu_addr  = a[13:0];
				ppu_rd_in = data_mem[i][0];
				ppu_wr_in = data_mem[i][1];
				check_en  = 1'b1;
				is_ppu    = 1'b1;
			end
			default:
			begin
				bad_ops++;
				$display("Step %0d has an unknown operation code", i);
			end
		endcase
	endtask

	initial
	begin
		romsel      = 1'b1;
		cpu_rw_in   = 1'b1;
		cpu_addr_in = 15'h0000;
		cpu_data_in = 8'h00;
		ppu_rd_in   = 1'b1;
		ppu_wr_in   = 1'b1;
		ppu_addr    = 14'h0000;
		check_en    = 1'b0;
		is_ppu      = 1'b0;
		exp_val     = 20'h00000;
		test_name   = "none";
		load_steps(n_steps);
		if (n_steps == 0)
		begin
			$display("Stimulus file missing or empty, nothing was run");
			$display("SIMULATION FAILED");
			$finish;
		end
		else
		begin
			@(negedge ppu_addr_in);
			for (int i = 0; i < n_steps; i++)
			begin
				@(posedge m2);
				#10;
				drive_step(i);
			end
			@(posedge m2);
			#10;
			check_en  = 1'b0;
			cpu_rw_in = 1'b1;
			@(posedge m2);
			$display("Checks: %0d, errors: %0d, bad steps: %0d", checks, errors, bad_ops);
			if (errors == 0 && bad_ops == 0 && checks > 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Watchdog, reset and tail fit well inside the 20 spare cycles
	initial
	begin
		wait (n_steps > 0);
		#((n_steps + 20) * 100);
		$display("Run timed out before all %0d steps finished", n_steps);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* cart_mapper_stim.txt */
# op name addr data expected; R exp = {0,fwe,foe,sce} {swe,soe,cpu_addr_out[13:0]}
# P exp = {0,rd,wr,a10} ppu_addr_out; P data bit 0 drives ppu_rd_in, bit 1 ppu_wr_in
R rst_nrom_c000 C000 00 58002
R rst_sram_6000 6000 00 78000
P rst_chr_wr 0000 01 600
W base_lo 5001 40 0
W mask 5002 1D 0
R base_a000 A000 00 58081
R mask_e000 E000 00 58081
W base_clr 5001 00 0
W mask_clr 5002 00 0
W sram_page 5005 02 0
W sram_en 5007 01 0
R sram_6000 6000 00 68002
W rom_6000 5007 21 0
R rom_at_6000 6000 00 58003
W uxrom 5006 02 0
W ux_latch 8000 05 0
R ux_8000 8000 00 5800A
R ux_c000 C000 00 5803E
W cnrom 5006 03 0
W cn_latch 8000 02 0
P cn_0400 0400 02 311
W mirror_a11 5007 0A 0
P cn_mir_0400 0400 02 211
P cn_mir_0800 0800 02 312
P cn_chr_wr 0400 01 411
W axrom 5006 07 0
W ax_latch 8000 13 0
R ax_8000 8000 00 5800C
P ax_a10 0000 02 300
W mmc1 5006 01 0
W mmc1_prg_b0 E000 01 0
W mmc1_prg_b1 E000 00 0
W mmc1_prg_b2 E000 01 0
W mmc1_prg_b3 E000 00 0
W mmc1_prg_b4 E000 00 0
R mmc1_8000 8000 00 5800A
R mmc1_c000 C000 00 5801E
W mmc1_part0 E000 01 0
W mmc1_part1 E000 01 0
W mmc1_bit7 8000 80 0
W mmc1_re_b0 E000 01 0
W mmc1_re_b1 E000 01 0
W mmc1_re_b2 E000 00 0
W mmc1_re_b3 E000 00 0
W mmc1_re_b4 E000 00 0
R mmc1_reload 8000 00 58006
W lockout 5007 80 0
W base_locked 5001 40 0
R lock_8000 8000 00 58006

/* files.f */
+incdir+.
mapper_pkg.sv
cart_config_regs.sv
bank_regs.sv
prg_bank_map.sv
chr_bank_map.sv
cart_mapper.sv
tb_clock_gen.sv
tb_mapper_checker.sv
tb_cart_mapper.sv
